/* src/sram_params.svh */
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// SRAM address bits small enough for short runs
`define SRAM_ADDR_BITS 6

// data bus width
`define SRAM_DATA_BITS 16

// expected-data queue holds 2**this entries
`define EXP_FIFO_DEPTH_LOG2 2

`endif

/* src/sram_bus_pkg.sv */
`include "sram_params.svh"

package sram_bus_pkg;

  // one memory address
  typedef logic [`SRAM_ADDR_BITS-1:0] addr_t;

  // one memory data word
  typedef logic [`SRAM_DATA_BITS-1:0] data_t;

endpackage

/* src/bist_pkg.sv */
package bist_pkg;

  // test patterns in the order they are run
  typedef enum logic [2:0] {
    PAT_ZEROS = 3'd0,
    PAT_ONES  = 3'd1,
    PAT_5555  = 3'd2,
    PAT_AAAA  = 3'd3,
    PAT_ADDR  = 3'd4
  } pattern_t;

  // bit i enables pattern_t value i
  typedef logic [4:0] pattern_mask_t;

  typedef enum logic [2:0] {IDLE, WRITE, READ, DRAIN, NEXT, HALT} seq_state_t;

endpackage

/* src/mem_req_if.sv */
interface mem_req_if;

  // request channel
  logic                req_valid;
  logic                req_write;
  sram_bus_pkg::addr_t req_addr;
  sram_bus_pkg::data_t req_wdata;
  logic                req_ready;

  // read response pulses for one cycle with no ready
  logic                rsp_valid;
  sram_bus_pkg::data_t rsp_rdata;

  modport master(
    output req_valid, req_write, req_addr, req_wdata,
    input req_ready, rsp_valid, rsp_rdata
  );

  modport slave(
    input req_valid, req_write, req_addr, req_wdata,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface

/* src/sram_controller.sv */
module sram_controller (
  input  logic                clk,
  input  logic                reset,
  input  sram_bus_pkg::data_t sram_dq_in,
  output sram_bus_pkg::addr_t sram_addr,
  output sram_bus_pkg::data_t sram_dq_out,
  output logic                sram_dq_oe,
  output logic                sram_we_n,
  output logic                sram_oe_n,
  output logic                sram_ce_n,
  mem_req_if.slave            bus
);

  typedef enum logic [1:0] {CTL_IDLE, CTL_WRITE, CTL_READ1, CTL_READ2} ctl_state_t;

  ctl_state_t state;
  logic       accept;

  assign bus.req_ready = (state == CTL_IDLE);
  assign accept = bus.req_valid && bus.req_ready;

  // strobes are registered so the pins change only on clock edges
  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= CTL_IDLE;
      sram_ce_n     <= 1'b1;
      sram_we_n     <= 1'b1;
      sram_oe_n     <= 1'b1;
      sram_dq_oe    <= 1'b0;
      bus.rsp_valid <= 1'b0;
    end else begin
      bus.rsp_valid <= 1'b0;
      case (state)
        CTL_IDLE: begin
          if (accept) begin
            state      <= bus.req_write ? CTL_WRITE : CTL_READ1;
            sram_ce_n  <= 1'b0;
            sram_we_n  <= !bus.req_write;
            sram_oe_n  <= bus.req_write;
            sram_dq_oe <= bus.req_write;
          end
        end
        CTL_WRITE: begin
          state      <= CTL_IDLE;
          sram_ce_n  <= 1'b1;
          sram_we_n  <= 1'b1;
          sram_dq_oe <= 1'b0;
        end
        CTL_READ1: begin
          state <= CTL_READ2;
        end
        CTL_READ2: begin
          // data has had two cycles of oe_n low
          state         <= CTL_IDLE;
          sram_ce_n     <= 1'b1;
          sram_oe_n     <= 1'b1;
          bus.rsp_valid <= 1'b1;
        end
        default: begin
          state <= CTL_IDLE;
        end
      endcase
    end
  end

  // address, write data and read data
  always_ff @(posedge clk) begin
    if (accept) begin
      sram_addr   <= bus.req_addr;
      sram_dq_out <= bus.req_wdata;
    end
    if (state == CTL_READ2) begin
      bus.rsp_rdata <= sram_dq_in;
    end
  end

  a_no_we_oe_overlap : assert property (
    @(posedge clk) disable iff (reset) !(!sram_we_n && !sram_oe_n)
  );

endmodule

/* src/pattern_generator.sv */
`include "sram_params.svh"

module pattern_generator (
  input  logic                    clk,
  input  logic                    reset,
  input  bist_pkg::pattern_mask_t pattern_mask,
  input  logic                    first,
  input  logic                    advance,
  input  sram_bus_pkg::addr_t     addr,
  output sram_bus_pkg::data_t     data,
  output logic                    last
);

  bist_pkg::pattern_t cur;
  bist_pkg::pattern_t first_sel;
  bist_pkg::pattern_t next_sel;

  // lowest enabled pattern, and the next enabled one above cur
  always_comb begin
    first_sel = bist_pkg::PAT_ZEROS;
    next_sel  = cur;
    last      = 1'b1;
    for (int i = $bits(bist_pkg::pattern_mask_t) - 1; i >= 0; i--) begin
      if (pattern_mask[i]) begin
        first_sel = bist_pkg::pattern_t'(i);
        if (i > int'(cur)) begin
          next_sel = bist_pkg::pattern_t'(i);
          last     = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cur <= bist_pkg::PAT_ZEROS;
    end else if (first) begin
      cur <= first_sel;
    end else if (advance) begin
      cur <= next_sel;
    end
  end

  always_comb begin
    case (cur)
      bist_pkg::PAT_ZEROS: data = '0;
      bist_pkg::PAT_ONES:  data = '1;
      bist_pkg::PAT_5555:  data = {(`SRAM_DATA_BITS / 2){2'b01}};
      bist_pkg::PAT_AAAA:  data = {(`SRAM_DATA_BITS / 2){2'b10}};
      // address zero-extended to the data width
      bist_pkg::PAT_ADDR:  data = sram_bus_pkg::data_t'(addr);
      default:             data = '0;
    endcase
  end

endmodule

/* src/expected_fifo.sv */
`include "sram_params.svh"

module expected_fifo #(
  parameter int WIDTH      = `SRAM_ADDR_BITS + `SRAM_DATA_BITS,
  parameter int DEPTH_LOG2 = `EXP_FIFO_DEPTH_LOG2
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] pop_data,
  output logic             empty,
  output logic             full
);

  logic [WIDTH-1:0]    mem [2**DEPTH_LOG2];
  // one extra bit tells full from empty
  logic [DEPTH_LOG2:0] wr_ptr;
  logic [DEPTH_LOG2:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

  // show-ahead read of the oldest entry
  assign pop_data = mem[rd_ptr[DEPTH_LOG2-1:0]];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[DEPTH_LOG2-1:0]] <= push_data;
    end
  end

endmodule

/* src/bist_sequencer.sv */
`include "sram_params.svh"

module bist_sequencer (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic                                       run_start,
  input  bist_pkg::pattern_mask_t                    pattern_mask,
  input  sram_bus_pkg::data_t                        pat_data,
  input  logic                                       pat_last,
  input  logic [`SRAM_ADDR_BITS+`SRAM_DATA_BITS-1:0] fifo_pop_data,
  input  logic                                       fifo_empty,
  input  logic                                       fifo_full,
  output logic                                       pat_first,
  output logic                                       pat_advance,
  output logic                                       fifo_push,
  output logic [`SRAM_ADDR_BITS+`SRAM_DATA_BITS-1:0] fifo_push_data,
  output logic                                       fifo_pop,
  output logic                                       run_end,
  output logic                                       mismatch,
  output sram_bus_pkg::addr_t                        mismatch_addr,
  output sram_bus_pkg::data_t                        mismatch_expected,
  output sram_bus_pkg::data_t                        mismatch_read,
  mem_req_if.master                                  bus
);

  bist_pkg::seq_state_t state;
  sram_bus_pkg::addr_t  addr;
  logic                 addr_last;
  logic                 accepted;
  logic                 checking;

  assign addr_last = (addr == '1);
  assign accepted = bus.req_valid && bus.req_ready;

  // reads wait while the queue is full
  assign bus.req_valid = (state == bist_pkg::WRITE) ||
                         ((state == bist_pkg::READ) && !fifo_full);
  assign bus.req_write = (state == bist_pkg::WRITE);
  assign bus.req_addr = addr;
  assign bus.req_wdata = pat_data;

  assign pat_first = (state == bist_pkg::IDLE) && run_start && (pattern_mask != '0);
  assign pat_advance = (state == bist_pkg::NEXT) && !pat_last;

  // expected entry queued as the read is accepted
  assign fifo_push = accepted && (state == bist_pkg::READ);
  assign fifo_push_data = {addr, pat_data};
  assign fifo_pop = bus.rsp_valid;

  assign {mismatch_addr, mismatch_expected} = fifo_pop_data;
  assign mismatch_read = bus.rsp_rdata;

  // responses still in flight after a failure are only drained
  assign checking = (state != bist_pkg::HALT);
  assign mismatch = bus.rsp_valid && checking && (bus.rsp_rdata != mismatch_expected);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= bist_pkg::IDLE;
      addr    <= '0;
      run_end <= 1'b0;
    end else begin
      run_end <= 1'b0;
      case (state)
        bist_pkg::IDLE: begin
          if (run_start) begin
            addr <= '0;
            // empty mask ends at once as a pass
            if (pattern_mask == '0) begin
              run_end <= 1'b1;
            end else begin
              state <= bist_pkg::WRITE;
            end
          end
        end
        bist_pkg::WRITE: begin
          if (accepted) begin
            // counter wraps back to 0 for the read pass
            addr <= addr + 1'b1;
            if (addr_last) begin
              state <= bist_pkg::READ;
            end
          end
        end
        bist_pkg::READ: begin
          if (accepted) begin
            addr <= addr + 1'b1;
            if (addr_last) begin
              state <= bist_pkg::DRAIN;
            end
          end
        end
        bist_pkg::DRAIN: begin
          if (fifo_empty) begin
            state <= bist_pkg::NEXT;
          end
        end
        bist_pkg::NEXT: begin
          if (pat_last) begin
            run_end <= 1'b1;
            state   <= bist_pkg::IDLE;
          end else begin
            state <= bist_pkg::WRITE;
          end
        end
        bist_pkg::HALT: begin
          if (fifo_empty) begin
            run_end <= 1'b1;
            state   <= bist_pkg::IDLE;
          end
        end
        default: begin
          state <= bist_pkg::IDLE;
        end
      endcase
      if (mismatch) begin
        state <= bist_pkg::HALT;
      end
    end
  end

  // one controller access in flight leaves at most one queued expectation
  a_single_outstanding : assert property (
    @(posedge clk) disable iff (reset) fifo_push |-> fifo_empty || fifo_pop
  );

  // every controller response must have a queued expectation
  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (reset) fifo_pop |-> !fifo_empty
  );

endmodule

/* src/bist_regs.sv */
module bist_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  bist_pkg::pattern_mask_t pattern_mask_in,
  input  logic                    run_end,
  input  logic                    mismatch,
  input  sram_bus_pkg::addr_t     mismatch_addr,
  input  sram_bus_pkg::data_t     mismatch_expected,
  input  sram_bus_pkg::data_t     mismatch_read,
  output logic                    run_start,
  output bist_pkg::pattern_mask_t pattern_mask,
  output logic                    busy,
  output logic                    done,
  output logic                    pass,
  output sram_bus_pkg::addr_t     fail_addr,
  output sram_bus_pkg::data_t     fail_expected,
  output sram_bus_pkg::data_t     fail_read
);

  always_ff @(posedge clk) begin
    if (reset) begin
      run_start <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      pass      <= 1'b1;
    end else begin
      run_start <= 1'b0;
      if (start && !busy && !run_start) begin
        run_start <= 1'b1;
        done      <= 1'b0;
        pass      <= 1'b1;
      end
      // busy follows the start pulse by one cycle
      if (run_start) begin
        busy <= 1'b1;
      end
      // pass still high means this is the first mismatch of the run
      if (mismatch && pass) begin
        pass <= 1'b0;
      end
      if (run_end) begin
        done <= 1'b1;
        busy <= 1'b0;
      end
    end
  end

  // mask and failure details
  always_ff @(posedge clk) begin
    if (start && !busy && !run_start) begin
      pattern_mask <= pattern_mask_in;
    end
    if (mismatch && pass) begin
      fail_addr     <= mismatch_addr;
      fail_expected <= mismatch_expected;
      fail_read     <= mismatch_read;
    end
  end

  // the sequencer only ends a run that was started here
  a_end_while_busy : assert property (
    @(posedge clk) disable iff (reset) run_end |-> busy
  );

endmodule

/* src/sram_bist_top.sv */
`include "sram_params.svh"

module sram_bist_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  bist_pkg::pattern_mask_t pattern_mask,
  input  sram_bus_pkg::data_t     sram_dq_in,
  output logic                    busy,
  output logic                    done,
  output logic                    pass,
  output sram_bus_pkg::addr_t     fail_addr,
  output sram_bus_pkg::data_t     fail_expected,
  output sram_bus_pkg::data_t     fail_read,
  output sram_bus_pkg::addr_t     sram_addr,
  output sram_bus_pkg::data_t     sram_dq_out,
  output logic                    sram_dq_oe,
  output logic                    sram_we_n,
  output logic                    sram_oe_n,
  output logic                    sram_ce_n
);

  logic                                       run_start;
  logic                                       run_end;
  bist_pkg::pattern_mask_t                    run_mask;
  logic                                       mismatch;
  sram_bus_pkg::addr_t                        mismatch_addr;
  sram_bus_pkg::data_t                        mismatch_expected;
  sram_bus_pkg::data_t                        mismatch_read;
  logic                                       pat_first;
  logic                                       pat_advance;
  logic                                       pat_last;
  sram_bus_pkg::data_t                        pat_data;
  logic                                       fifo_push;
  logic                                       fifo_pop;
  logic                                       fifo_empty;
  logic                                       fifo_full;
  logic [`SRAM_ADDR_BITS+`SRAM_DATA_BITS-1:0] fifo_push_data;
  logic [`SRAM_ADDR_BITS+`SRAM_DATA_BITS-1:0] fifo_pop_data;

  mem_req_if bus_if ();

  bist_regs u_regs (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .pattern_mask_in  (pattern_mask),
    .run_end          (run_end),
    .mismatch         (mismatch),
    .mismatch_addr    (mismatch_addr),
    .mismatch_expected(mismatch_expected),
    .mismatch_read    (mismatch_read),
    .run_start        (run_start),
    .pattern_mask     (run_mask),
    .busy             (busy),
    .done             (done),
    .pass             (pass),
    .fail_addr        (fail_addr),
    .fail_expected    (fail_expected),
    .fail_read        (fail_read)
  );

  bist_sequencer u_seq (
    .clk              (clk),
    .reset            (reset),
    .run_start        (run_start),
    .pattern_mask     (run_mask),
    .pat_data         (pat_data),
    .pat_last         (pat_last),
    .fifo_pop_data    (fifo_pop_data),
    .fifo_empty       (fifo_empty),
    .fifo_full        (fifo_full),
    .pat_first        (pat_first),
    .pat_advance      (pat_advance),
    .fifo_push        (fifo_push),
    .fifo_push_data   (fifo_push_data),
    .fifo_pop         (fifo_pop),
    .run_end          (run_end),
    .mismatch         (mismatch),
    .mismatch_addr    (mismatch_addr),
    .mismatch_expected(mismatch_expected),
    .mismatch_read    (mismatch_read),
    .bus              (bus_if.master)
  );

  // data word follows the address on the request bus
  pattern_generator u_pat (
    .clk         (clk),
    .reset       (reset),
    .pattern_mask(run_mask),
    .first       (pat_first),
    .advance     (pat_advance),
    .addr        (bus_if.req_addr),
    .data        (pat_data),
    .last        (pat_last)
  );

  expected_fifo u_exp_fifo (
    .clk      (clk),
    .reset    (reset),
    .push     (fifo_push),
    .push_data(fifo_push_data),
    .pop      (fifo_pop),
    .pop_data (fifo_pop_data),
    .empty    (fifo_empty),
    .full     (fifo_full)
  );

  sram_controller u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .sram_dq_in (sram_dq_in),
    .sram_addr  (sram_addr),
    .sram_dq_out(sram_dq_out),
    .sram_dq_oe (sram_dq_oe),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n),
    .bus        (bus_if.slave)
  );

endmodule

/* test/sram_model.sv */
`include "sram_params.svh"

module sram_model (
  input  logic                                  clk,
  input  sram_bus_pkg::addr_t                   addr,
  input  sram_bus_pkg::data_t                   dq_in,
  input  logic                                  dq_oe,
  input  logic                                  we_n,
  input  logic                                  oe_n,
  input  logic                                  ce_n,
  output sram_bus_pkg::data_t                   dq_out,
  input  logic                                  fault_en,
  input  sram_bus_pkg::addr_t                   fault_addr,
  input  logic [$clog2(`SRAM_DATA_BITS)-1:0]    fault_bit
);
  timeunit 1ns;
  timeprecision 1ps;

  sram_bus_pkg::data_t mem [2**`SRAM_ADDR_BITS];
  sram_bus_pkg::data_t stuck;

  // write lands on the edge that ends the strobe cycle
  always_ff @(posedge clk) begin
    if (!ce_n && !we_n && dq_oe) begin
      mem[addr] <= dq_in;
    end
  end

  // stuck-at-1 bit on the faulty cell
  always_comb begin
    stuck = '0;
    if (fault_en && (addr == fault_addr)) begin
      stuck[fault_bit] = 1'b1;
    end
  end

  // bus reads zero when not driven by the memory
  assign dq_out = (!ce_n && !oe_n) ? (mem[addr] | stuck) : '0;

endmodule

/* test/tb_sram_bist.sv */
`include "sram_params.svh"

module tb_sram_bist;
  timeunit 1ns;
  timeprecision 1ps;

  // full run of five patterns writing and reading every address
  localparam int RUN_NS = 5 * 2 * (1 << `SRAM_ADDR_BITS) * 4 * 40;
  localparam int WATCHDOG_NS = 4 * RUN_NS + 20000;

  logic                    clk;
  logic                    reset;
  logic                    start;
  bist_pkg::pattern_mask_t pattern_mask;
  sram_bus_pkg::data_t     sram_dq_in;
  logic                    busy;
  logic                    done;
  logic                    pass;
  sram_bus_pkg::addr_t     fail_addr;
  sram_bus_pkg::data_t     fail_expected;
  sram_bus_pkg::data_t     fail_read;
  sram_bus_pkg::addr_t     sram_addr;
  sram_bus_pkg::data_t     sram_dq_out;
  logic                    sram_dq_oe;
  logic                    sram_we_n;
  logic                    sram_oe_n;
  logic                    sram_ce_n;

  logic                    fault_en;
  sram_bus_pkg::addr_t     fault_addr;
  logic [3:0]              fault_bit;

  logic [2:0]              test_id;
  logic                    expect_pass;
  logic                    idle_window;
  sram_bus_pkg::data_t     exp_expected;
  sram_bus_pkg::data_t     exp_read;
  logic [7:0]              reached;
  logic                    done_q;
  logic [6:0]              status_vec;
  logic                    no_writes;
  integer                  seed;

  sram_bist_top UUT (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .pattern_mask (pattern_mask),
    .sram_dq_in   (sram_dq_in),
    .busy         (busy),
    .done         (done),
    .pass         (pass),
    .fail_addr    (fail_addr),
    .fail_expected(fail_expected),
    .fail_read    (fail_read),
    .sram_addr    (sram_addr),
    .sram_dq_out  (sram_dq_out),
    .sram_dq_oe   (sram_dq_oe),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .sram_ce_n    (sram_ce_n)
  );

  sram_model u_sram (
    .clk       (clk),
    .addr      (sram_addr),
    .dq_in     (sram_dq_out),
    .dq_oe     (sram_dq_oe),
    .we_n      (sram_we_n),
    .oe_n      (sram_oe_n),
    .ce_n      (sram_ce_n),
    .dq_out    (sram_dq_in),
    .fault_en  (fault_en),
    .fault_addr(fault_addr),
    .fault_bit (fault_bit)
  );

  always #20 clk = ~clk;

  assign status_vec = {busy, done, pass, sram_dq_oe, sram_we_n, sram_oe_n, sram_ce_n};
  assign no_writes = (test_id == 3'd6);

  // word written for a pattern at an address
  function automatic sram_bus_pkg::data_t pattern_word(input int pat,
                                                       input sram_bus_pkg::addr_t a);
    case (pat)
      0:       pattern_word = 16'h0000;
      1:       pattern_word = 16'hffff;
      2:       pattern_word = 16'h5555;
      3:       pattern_word = 16'haaaa;
      default: pattern_word = sram_bus_pkg::data_t'(a);
    endcase
  endfunction

  // first enabled pattern whose word is 0 at the stuck bit
  function automatic sram_bus_pkg::data_t first_fail_word(input bist_pkg::pattern_mask_t mask,
                                                          input sram_bus_pkg::addr_t a,
                                                          input logic [3:0] bit_pos);
    sram_bus_pkg::data_t w;
    logic                found;
    found = 1'b0;
    first_fail_word = '0;
    for (int p = 0; p < 5; p++) begin
      if (!found && mask[p]) begin
        w = pattern_word(p, a);
        if (!w[bit_pos]) begin
          first_fail_word = w;
          found = 1'b1;
        end
      end
    end
  endfunction

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    $display("test failed");
    $display("error %s: got 0x%0h, expected 0x%0h", name, got, expected);
    $fatal(1);
  endtask

  task automatic fail_with_reason(input string what);
    $display("test failed");
    $display("%s", what);
    $fatal(1);
  endtask

  // one run from start to done
  task automatic run_bist(input logic [2:0] id, input bist_pkg::pattern_mask_t mask,
                          input logic exp_pass);
    @(posedge clk);
    test_id      <= id;
    expect_pass  <= exp_pass;
    pattern_mask <= mask;
    start        <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    while (done !== 1'b1) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
  endtask

  a_idle_status : assert property (
    @(posedge clk) disable iff (reset) idle_window |-> status_vec == 7'h17
  ) else value_error("{busy,done,pass,sram_dq_oe,sram_we_n,sram_oe_n,sram_ce_n}",
                     32'(status_vec), 32'h17);

  a_strobe_overlap : assert property (
    @(posedge clk) disable iff (reset) busy |-> !(!sram_we_n && !sram_oe_n)
  ) else fail_with_reason("sram_we_n and sram_oe_n were low together during a run");

  a_done_while_busy : assert property (
    @(posedge clk) disable iff (reset) busy |-> !done
  ) else fail_with_reason("done stayed high while a new run was busy");

  a_no_write_strobe : assert property (
    @(posedge clk) disable iff (reset) no_writes |-> sram_we_n
  ) else fail_with_reason("a write strobe appeared with no pattern enabled");

  a_pass_clean : assert property (
    @(posedge clk) disable iff (reset) $rose(done) && expect_pass |-> pass
  ) else value_error("pass", 32'(pass), 32'h1);

  a_pass_fault : assert property (
    @(posedge clk) disable iff (reset) $rose(done) && !expect_pass |-> !pass
  ) else value_error("pass", 32'(pass), 32'h0);

  a_fail_addr : assert property (
    @(posedge clk) disable iff (reset) $rose(done) && !expect_pass |-> fail_addr == fault_addr
  ) else value_error("fail_addr", 32'(fail_addr), 32'(fault_addr));

  a_fail_expected : assert property (
    @(posedge clk) disable iff (reset)
      $rose(done) && !expect_pass |-> fail_expected == exp_expected
  ) else value_error("fail_expected", 32'(fail_expected), 32'(exp_expected));

  a_fail_read : assert property (
    @(posedge clk) disable iff (reset) $rose(done) && !expect_pass |-> fail_read == exp_read
  ) else value_error("fail_read", 32'(fail_read), 32'(exp_read));

  // which behaviours have actually been exercised
  always @(posedge clk) begin
    if (reset) begin
      done_q  <= 1'b0;
      reached <= '0;
    end else begin
      done_q <= done;
      if (done && !done_q) begin
        reached[test_id] <= 1'b1;
      end
      if (idle_window) begin
        reached[1] <= 1'b1;
      end
    end
  end

  initial begin
    logic [31:0]         rnd;
    sram_bus_pkg::addr_t cand_addr;
    logic [3:0]          cand_bit;
    sram_bus_pkg::data_t word;
    seed         = 32'ha153_3c97;
    clk          = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    pattern_mask = '0;
    fault_en     = 1'b0;
    fault_addr   = '0;
    fault_bit    = '0;
    test_id      = '0;
    expect_pass  = 1'b1;
    idle_window  = 1'b0;
    exp_expected = '0;
    exp_read     = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    idle_window <= 1'b1;
    repeat (4) @(posedge clk);
    idle_window <= 1'b0;

    run_bist(3'd2, 5'b11111, 1'b1);

    // stuck bit anywhere with all patterns enabled
    rnd = $random(seed);
    cand_addr = rnd[`SRAM_ADDR_BITS-1:0];
    rnd = $random(seed);
    cand_bit = rnd[3:0];
    word = first_fail_word(5'b11111, cand_addr, cand_bit);
    fault_en     <= 1'b1;
    fault_addr   <= cand_addr;
    fault_bit    <= cand_bit;
    exp_expected <= word;
    exp_read     <= word ^ (sram_bus_pkg::data_t'(1) << cand_bit);
    run_bist(3'd3, 5'b11111, 1'b0);

    // fault removed so status must come back clean
    fault_en <= 1'b0;
    run_bist(3'd5, 5'b11111, 1'b1);

    // address pattern only with the stuck bit 0 in the address word
    rnd = $random(seed);
    cand_addr = rnd[`SRAM_ADDR_BITS-1:0];
    rnd = $random(seed);
    cand_bit = rnd[3:0];
    word = pattern_word(4, cand_addr);
    while (word[cand_bit]) begin
      rnd = $random(seed);
      cand_addr = rnd[`SRAM_ADDR_BITS-1:0];
      rnd = $random(seed);
      cand_bit = rnd[3:0];
      word = pattern_word(4, cand_addr);
    end
    word = first_fail_word(5'b10000, cand_addr, cand_bit);
    fault_en     <= 1'b1;
    fault_addr   <= cand_addr;
    fault_bit    <= cand_bit;
    exp_expected <= word;
    exp_read     <= word ^ (sram_bus_pkg::data_t'(1) << cand_bit);
    run_bist(3'd4, 5'b10000, 1'b0);

    fault_en <= 1'b0;
    run_bist(3'd6, 5'b00000, 1'b1);

    if (reached[6:1] == 6'b111111) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $display("not every check was reached during the run");
      $fatal(1);
    end
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("test failed");
    $display("timeout: the self-test runs did not finish in time");
    $fatal(1);
  end

endmodule

/* compile.f */
+incdir+src
src/sram_bus_pkg.sv
src/bist_pkg.sv
src/mem_req_if.sv
src/sram_controller.sv
src/pattern_generator.sv
src/expected_fifo.sv
src/bist_sequencer.sv
src/bist_regs.sv
src/sram_bist_top.sv
test/sram_model.sv
test/tb_sram_bist.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tb_sram_bist -o tb_sram_bist

sim_output=$(./obj_dir/tb_sram_bist || true)
echo "$sim_output"
echo "$sim_output" | grep -qx "test passed"
